// ==== include/rs_defines.svh ====
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// sizing of the out-of-order core
// every width in the package and the modules is derived from these

// data path width, results wrap at this many bits
`define RS_XLEN 32

// architectural registers seen by the instruction stream
`define RS_NUM_REGS 8

// result tag width, 16 tags outnumber the producers that can be in flight
// (station depth, one in the ALU, one being accepted) so a pending tag is
// never handed out a second time
`define RS_TAG_LEN 4

// reservation station slots
`define RS_NUM_ENTRIES 8

// cycles from the issue edge to the multiply broadcast
`define RS_MUL_CYCLES 4

`endif

// ==== hdl/rs_pkg.sv ====
`include "rs_defines.svh"

package rs_pkg;

    typedef logic [$clog2(`RS_NUM_REGS)-1:0]    reg_idx_t; // architectural register number
    typedef logic [`RS_TAG_LEN-1:0]             tag_t;     // name of a pending result
    typedef logic [$clog2(`RS_NUM_ENTRIES)-1:0] age_t;     // 0 is the oldest entry

    // ALU operations, the encoding fits one three bit word
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_MUL
    } alu_func_e;

    // one operand word, holding the value once the source is known and the
    // producer tag while it is still in flight
    typedef union packed {
        logic [`RS_XLEN-1:0] value;
        struct packed {
            logic [`RS_XLEN-`RS_TAG_LEN-1:0] pad; // kept at zero
            tag_t                            tag;
        } pend;
    } operand_u;

    typedef struct packed {
        alu_func_e           func;
        reg_idx_t            rd;
        reg_idx_t            rs1;
        reg_idx_t            rs2;
        logic                use_imm; // imm stands in for rs2
        logic [`RS_XLEN-1:0] imm;
    } insn_t;

    typedef struct packed {
        logic      valid;
        alu_func_e func;
        tag_t      dst;
        logic      ready1; // op1 holds a value
        logic      ready2; // op2 holds a value
        operand_u  op1;
        operand_u  op2;
        age_t      age;
    } rs_entry_t;

    typedef struct packed {
        alu_func_e           func;
        tag_t                dst;
        logic [`RS_XLEN-1:0] op1;
        logic [`RS_XLEN-1:0] op2;
    } issue_t;

    typedef struct packed {
        logic                valid;
        tag_t                tag;
        logic [`RS_XLEN-1:0] value;
    } bcast_t;

endpackage

// ==== hdl/dispatch_stage.sv ====
`include "rs_defines.svh"

module dispatch_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  rs_pkg::insn_t       in_insn,
    output logic                in_ready,
    input  logic                rs_full,
    input  rs_pkg::bcast_t      bcast,
    output logic                alloc_valid,
    output rs_pkg::rs_entry_t   alloc_entry,
    input  rs_pkg::reg_idx_t    rd_addr,
    output logic                rd_pending,
    output logic [`RS_XLEN-1:0] rd_value
);
    import rs_pkg::*;

    // register map, a pending entry is waiting for the result named by map_tag
    logic                map_pend  [`RS_NUM_REGS];
    tag_t                map_tag   [`RS_NUM_REGS];
    logic [`RS_XLEN-1:0] map_value [`RS_NUM_REGS];

    tag_t     next_tag;     // tag handed to the next accepted instruction
    logic     accept;
    logic     src1_ready;
    logic     src2_ready;
    operand_u src1_op;
    operand_u src2_op;

    // reads one source through the map, a broadcast in this very cycle
    // would be missed by the station so it is captured here instead
    function automatic void lookup_src(input reg_idx_t r, output logic rdy,
                                       output operand_u op);
        op = '0;
        if (!map_pend[r]) begin
            rdy      = 1'b1;
            op.value = map_value[r];
        end else if (bcast.valid && bcast.tag == map_tag[r]) begin
            rdy      = 1'b1;
            op.value = bcast.value; // producer finishing right now
        end else begin
            rdy         = 1'b0;
            op.pend.tag = map_tag[r];
        end
    endfunction

    // full is judged only here, and nothing is taken while reset is high
    assign in_ready = !reset && !rs_full;
    assign accept   = in_valid && in_ready;

    always_comb begin
        lookup_src(in_insn.rs1, src1_ready, src1_op);
        lookup_src(in_insn.rs2, src2_ready, src2_op);
        if (in_insn.use_imm) begin
            src2_ready    = 1'b1; // immediate never waits
            src2_op       = '0;
            src2_op.value = in_insn.imm;
        end
    end

    // the station fills in the age rank itself
    always_comb begin
        alloc_valid        = accept;
        alloc_entry        = '0;
        alloc_entry.valid  = accept;
        alloc_entry.func   = in_insn.func;
        alloc_entry.dst    = next_tag;
        alloc_entry.ready1 = src1_ready;
        alloc_entry.ready2 = src2_ready;
        alloc_entry.op1    = src1_op;
        alloc_entry.op2    = src2_op;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            next_tag <= '0;
            for (int i = 0; i < `RS_NUM_REGS; i++) begin
                map_pend[i]  <= 1'b0;
                map_value[i] <= '0; // registers read as zero after reset
            end
        end else begin
            // results land only in entries still waiting on that tag
            for (int i = 0; i < `RS_NUM_REGS; i++) begin
                if (bcast.valid && map_pend[i] && map_tag[i] == bcast.tag) begin
                    map_pend[i]  <= 1'b0;
                    map_value[i] <= bcast.value;
                end
            end
            // renaming comes after the writeback so a new producer wins
            if (accept) begin
                map_pend[in_insn.rd] <= 1'b1;
                map_tag[in_insn.rd]  <= next_tag;
                next_tag             <= next_tag + 1'b1; // wraps through all tags
            end
        end
    end

    assign rd_pending = map_pend[rd_addr];
    assign rd_value   = map_value[rd_addr]; // last committed value, stale while pending

endmodule

// ==== hdl/reservation_station.sv ====
`include "rs_defines.svh"

module reservation_station (
    input  logic              clk,
    input  logic              reset,
    input  logic              alloc_valid,
    input  rs_pkg::rs_entry_t alloc_entry,
    output logic              rs_full,
    input  rs_pkg::bcast_t    bcast,
    input  logic              alu_busy,
    output logic              iss_valid,
    output rs_pkg::issue_t    iss
);
    import rs_pkg::*;

    localparam int N     = `RS_NUM_ENTRIES;
    localparam int IDX_W = $clog2(N);
    localparam int CNT_W = $clog2(N + 1); // occupancy must reach N

    rs_entry_t        entries_q [N];
    rs_entry_t        entries_d [N];
    logic [CNT_W-1:0] occupancy;
    logic [N-1:0]     wake1;     // broadcast supplies op1 of this entry
    logic [N-1:0]     wake2;
    logic [N-1:0]     ready_vec; // both operands known, counting the bypass
    logic [IDX_W-1:0] sel_idx;
    age_t             sel_age;
    logic [IDX_W-1:0] free_idx;
    logic             free_found;
    logic             do_issue;

    // count of live entries, also the age rank the next entry would take
    always_comb begin
        occupancy = '0;
        for (int i = 0; i < N; i++) begin
            if (entries_q[i].valid) begin
                occupancy = occupancy + 1'b1;
            end
        end
    end

    assign rs_full = (occupancy == CNT_W'(N));

    // tag compare against the broadcast, the union is read as a tag here
    always_comb begin
        for (int i = 0; i < N; i++) begin
            wake1[i] = bcast.valid && entries_q[i].valid && !entries_q[i].ready1
                       && entries_q[i].op1.pend.tag == bcast.tag;
            wake2[i] = bcast.valid && entries_q[i].valid && !entries_q[i].ready2
                       && entries_q[i].op2.pend.tag == bcast.tag;
            ready_vec[i] = entries_q[i].valid
                           && (entries_q[i].ready1 || wake1[i])
                           && (entries_q[i].ready2 || wake2[i]);
        end
    end

    // oldest ready entry, ranks are unique among live entries
    always_comb begin
        sel_idx = '0;
        sel_age = '1;
        for (int i = 0; i < N; i++) begin
            if (ready_vec[i] && entries_q[i].age <= sel_age) begin
                sel_idx = IDX_W'(i);
                sel_age = entries_q[i].age;
            end
        end
    end

    // nothing issues while the multiplier holds the ALU
    assign do_issue  = (|ready_vec) && !alu_busy;
    assign iss_valid = do_issue;

    // operands not yet ready can only be waiting on the current broadcast
    always_comb begin
        iss.func = entries_q[sel_idx].func;
        iss.dst  = entries_q[sel_idx].dst;
        iss.op1  = entries_q[sel_idx].ready1 ? entries_q[sel_idx].op1.value : bcast.value;
        iss.op2  = entries_q[sel_idx].ready2 ? entries_q[sel_idx].op2.value : bcast.value;
    end

    // lowest numbered empty slot takes the new entry
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = 0; i < N; i++) begin
            if (!entries_q[i].valid && !free_found) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            entries_d[i] = entries_q[i];
            if (wake1[i]) begin
                entries_d[i].ready1    = 1'b1;
                entries_d[i].op1.value = bcast.value; // tag is replaced by the result
            end
            if (wake2[i]) begin
                entries_d[i].ready2    = 1'b1;
                entries_d[i].op2.value = bcast.value;
            end
            // everything younger than the issued entry moves up one rank
            if (do_issue && entries_q[i].valid && entries_q[i].age > sel_age) begin
                entries_d[i].age = entries_q[i].age - 1'b1;
            end
        end
        if (do_issue) begin
            entries_d[sel_idx].valid = 1'b0;
        end
        // a slot freed by this issue is not reused until the next edge
        if (alloc_valid && free_found) begin
            entries_d[free_idx]       = alloc_entry;
            entries_d[free_idx].valid = 1'b1;
            entries_d[free_idx].age   = age_t'(occupancy - CNT_W'(do_issue));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < N; i++) begin
                entries_q[i].valid <= 1'b0;
            end
        end else begin
            entries_q <= entries_d;
        end
    end

endmodule

// ==== hdl/alu_stage.sv ====
`include "rs_defines.svh"

module alu_stage (
    input  logic           clk,
    input  logic           reset,
    input  logic           iss_valid,
    input  rs_pkg::issue_t iss,
    output logic           alu_busy,
    output rs_pkg::bcast_t bcast
);
    import rs_pkg::*;

    localparam int CNT_W   = $clog2(`RS_MUL_CYCLES + 1);
    localparam int SHAMT_W = $clog2(`RS_XLEN);

    logic [CNT_W-1:0]    mul_cnt;   // cycles left before the product is broadcast
    tag_t                mul_tag;
    logic [`RS_XLEN-1:0] mul_value;
    logic [`RS_XLEN-1:0] product;
    logic [`RS_XLEN-1:0] fast_result;

    assign product = iss.op1 * iss.op2; // low half only, wraps like the rest

    always_comb begin
        case (iss.func)
            ALU_ADD: fast_result = iss.op1 + iss.op2;
            ALU_SUB: fast_result = iss.op1 - iss.op2;
            ALU_AND: fast_result = iss.op1 & iss.op2;
            ALU_OR:  fast_result = iss.op1 | iss.op2;
            ALU_XOR: fast_result = iss.op1 ^ iss.op2;
            ALU_SLL: fast_result = iss.op1 << iss.op2[SHAMT_W-1:0];
            default: fast_result = '0; // multiply takes the slow path
        endcase
    end

    assign alu_busy = (mul_cnt != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            bcast.valid <= 1'b0;
            mul_cnt     <= '0;
        end else begin
            bcast.valid <= 1'b0; // each result is on the bus for one cycle
            if (mul_cnt != '0) begin
                mul_cnt <= mul_cnt - 1'b1;
                if (mul_cnt == CNT_W'(1)) begin
                    bcast <= '{valid: 1'b1, tag: mul_tag, value: mul_value};
                end
            end
            // the station never issues while busy, so the two branches never collide
            if (iss_valid) begin
                if (iss.func == ALU_MUL) begin
                    mul_cnt   <= CNT_W'(`RS_MUL_CYCLES - 1);
                    mul_tag   <= iss.dst;
                    mul_value <= product;
                end else begin
                    bcast <= '{valid: 1'b1, tag: iss.dst, value: fast_result};
                end
            end
        end
    end

endmodule

// ==== hdl/ooo_core_top.sv ====
`include "rs_defines.svh"

module ooo_core_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  rs_pkg::insn_t       in_insn,
    output logic                in_ready,
    output rs_pkg::bcast_t      result,
    input  rs_pkg::reg_idx_t    rd_addr,
    output logic                rd_pending,
    output logic [`RS_XLEN-1:0] rd_value
);
    import rs_pkg::*;

    logic      alloc_valid;
    rs_entry_t alloc_entry;
    logic      rs_full;
    logic      iss_valid;
    issue_t    iss;
    logic      alu_busy;
    bcast_t    bcast;        // result bus, seen by the station, the map and the outside

    assign result = bcast;

    dispatch_stage u_dispatch (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_insn     (in_insn),
        .in_ready    (in_ready),
        .rs_full     (rs_full),
        .bcast       (bcast),
        .alloc_valid (alloc_valid),
        .alloc_entry (alloc_entry),
        .rd_addr     (rd_addr),
        .rd_pending  (rd_pending),
        .rd_value    (rd_value)
    );

    reservation_station u_rs (
        .clk         (clk),
        .reset       (reset),
        .alloc_valid (alloc_valid),
        .alloc_entry (alloc_entry),
        .rs_full     (rs_full),
        .bcast       (bcast),
        .alu_busy    (alu_busy),
        .iss_valid   (iss_valid),
        .iss         (iss)
    );

    alu_stage u_alu (
        .clk       (clk),
        .reset     (reset),
        .iss_valid (iss_valid),
        .iss       (iss),
        .alu_busy  (alu_busy),
        .bcast     (bcast)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk
);

    // free running clock, 20 time units per period
    initial begin
        clk = 1'b0;
    end

    always begin
        #10 clk = ~clk; // half period
    end

endmodule

// ==== verification/ooo_core_props.sv ====
module ooo_core_props (
    input logic           clk,
    input logic           reset,
    input logic           in_ready,
    input logic           rs_full,
    input logic           iss_valid,
    input logic           alu_busy,
    input rs_pkg::bcast_t result
);

    // nothing can have issued yet, so the first cycle out of reset is quiet
    bcast_quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !result.valid)
        else $error("result bus valid in the first cycle after reset");

    // a full station must stop the input
    no_accept_when_full: assert property (@(posedge clk) disable iff (reset)
        rs_full |-> !in_ready)
        else $error("in_ready high while the station is full");

    // the multiplier owns the ALU until its product leaves
    no_issue_while_busy: assert property (@(posedge clk) disable iff (reset)
        !(alu_busy && iss_valid))
        else $error("issue while the ALU is busy with a multiply");

    // back to back results are fine, but one tag never stays on the bus
    single_cycle_result: assert property (@(posedge clk) disable iff (reset)
        result.valid |=> (!result.valid || result.tag != $past(result.tag)))
        else $error("the same result stayed on the bus for a second cycle");

endmodule

bind ooo_core_top ooo_core_props u_props (
    .clk       (clk),
    .reset     (reset),
    .in_ready  (in_ready),
    .rs_full   (rs_full),
    .iss_valid (iss_valid),
    .alu_busy  (alu_busy),
    .result    (result)
);

// ==== verification/ooo_core_tb.sv ====
`include "rs_defines.svh"

module ooo_core_tb;
    import rs_pkg::*;

    localparam int NUM_TAGS       = 1 << `RS_TAG_LEN;
    localparam int TIMEOUT_CYCLES = 2100; // 400 instructions at 5 cycles, plus 100 spare
    localparam int MODE_INDEP     = 0;
    localparam int MODE_CHAIN     = 1;
    localparam int MODE_MUL       = 2;
    localparam int MODE_MIX       = 3;

    logic                clk;
    logic                reset;
    logic                in_valid;
    insn_t               in_insn;
    logic                in_ready;
    bcast_t              result;
    reg_idx_t            rd_addr;
    logic                rd_pending;
    logic [`RS_XLEN-1:0] rd_value;

    // program order model, one value per register and one per tag in flight
    logic [`RS_XLEN-1:0] model_regs [`RS_NUM_REGS];
    logic [`RS_XLEN-1:0] tag_value  [NUM_TAGS];
    logic                tag_busy   [NUM_TAGS];
    tag_t                model_tag;      // mirrors the dispatch tag counter
    int                  outstanding;
    int                  stall_count;
    int                  cycle_count;
    string               test_name;

    tb_clock_gen u_clk (.clk(clk));

    ooo_core_top uut (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_insn    (in_insn),
        .in_ready   (in_ready),
        .result     (result),
        .rd_addr    (rd_addr),
        .rd_pending (rd_pending),
        .rd_value   (rd_value)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // results wrap at the data width, shifts use only five bits of b
    function automatic logic [`RS_XLEN-1:0] reference_alu(input alu_func_e f,
                                                          input logic [`RS_XLEN-1:0] a,
                                                          input logic [`RS_XLEN-1:0] b);
        case (f)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            default: return a * b; // multiply keeps the low word
        endcase
    endfunction

    // the tag only selects the model entry, the value is what gets judged
    task automatic compare_result(input string test, input bcast_t exp, input bcast_t act);
        if (act.value != exp.value) begin
            $display("Error: %s result for tag %0d expected %h actual %h",
                     test, exp.tag, exp.value, act.value);
            abort_run("result bus disagrees with the model");
        end
    endtask

    task automatic compare_reg(input string test, input reg_idx_t idx,
                               input logic [`RS_XLEN-1:0] exp, input logic act_pending,
                               input logic [`RS_XLEN-1:0] act);
        if (act_pending) begin
            abort_run($sformatf("%s: register %0d is still pending after the drain", test, idx));
        end
        if (act != exp) begin
            $display("Error: %s register %0d expected %h actual %h", test, idx, exp, act);
            abort_run("register read port disagrees with the model");
        end
    endtask

    // the model runs each instruction the moment it is accepted
    task automatic accept_insn(input insn_t insn);
        logic [`RS_XLEN-1:0] a;
        logic [`RS_XLEN-1:0] b;
        if (tag_busy[model_tag]) begin
            abort_run($sformatf("tag %0d was handed out again while still pending", model_tag));
        end
        a = model_regs[insn.rs1];
        b = insn.use_imm ? insn.imm : model_regs[insn.rs2];
        tag_value[model_tag] = reference_alu(insn.func, a, b);
        tag_busy[model_tag]  = 1'b1;
        model_regs[insn.rd]  = tag_value[model_tag];
        model_tag            = model_tag + 1'b1; // same wrapping count as dispatch
        outstanding++;
    endtask

    task automatic check_broadcast(input bcast_t act);
        bcast_t exp;
        if (!tag_busy[act.tag]) begin
            abort_run($sformatf("a result came for tag %0d with nothing outstanding", act.tag));
        end
        exp = '{valid: 1'b1, tag: act.tag, value: tag_value[act.tag]};
        compare_result(test_name, exp, act);
        tag_busy[act.tag] = 1'b0; // a second broadcast of this tag is an error
        outstanding--;
    endtask

    // samples happen before this edge's updates, so all values are the settled ones
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("the run hung, %0d results still outstanding after %0d cycles",
                                outstanding, cycle_count));
        end
        if (!reset) begin
            if (result.valid) begin
                check_broadcast(result);
            end
            if (in_valid && in_ready) begin
                accept_insn(in_insn);
            end else if (in_valid) begin
                stall_count++; // the station pushed back on this cycle
            end
        end
    end

    function automatic insn_t random_insn(input int mode, input reg_idx_t prev_rd);
        insn_t insn;
        insn.func    = alu_func_e'(3'($urandom_range(0, 6)));
        insn.rd      = reg_idx_t'($urandom_range(0, `RS_NUM_REGS - 1));
        insn.rs1     = reg_idx_t'($urandom_range(0, `RS_NUM_REGS - 1));
        insn.rs2     = reg_idx_t'($urandom_range(0, `RS_NUM_REGS - 1));
        insn.use_imm = ($urandom_range(0, 3) == 0);
        insn.imm     = $urandom();
        case (mode)
            MODE_INDEP: begin
                insn.rd      = reg_idx_t'($urandom_range(1, `RS_NUM_REGS - 1));
                insn.rs1     = '0; // r0 is never written here, so nothing waits
                insn.use_imm = 1'b1;
            end
            MODE_CHAIN: insn.rs1 = prev_rd; // each one waits on the one before
            MODE_MUL: begin
                if ($urandom_range(0, 3) != 0) begin
                    insn.func = ALU_MUL;
                end
            end
            default: ; // the random mix keeps every field as drawn
        endcase
        return insn;
    endfunction

    // reads each register through the port, one per cycle
    task automatic check_registers(input string test);
        for (int i = 0; i < `RS_NUM_REGS; i++) begin
            rd_addr <= reg_idx_t'(i);
            @(posedge clk);
            compare_reg(test, reg_idx_t'(i), model_regs[i], rd_pending, rd_value);
        end
    endtask

    task automatic run_test(input string name, input int mode, input int count);
        insn_t    insn;
        reg_idx_t prev_rd;
        prev_rd   = '0;
        test_name = name;
        for (int n = 0; n < count; n++) begin
            insn    = random_insn(mode, prev_rd);
            prev_rd = insn.rd;
            in_valid <= 1'b1;
            in_insn  <= insn;
            do @(posedge clk); while (!in_ready); // held steady until taken
        end
        in_valid <= 1'b0;
        do @(posedge clk); while (outstanding != 0); // timeout guards this wait
        check_registers(name);
    endtask

    initial begin
        void'($urandom(75));
        reset          = 1'b1;
        in_valid       = 1'b0;
        in_insn        = '0;
        rd_addr        = '0;
        model_tag      = '0;
        outstanding    = 0;
        stall_count    = 0;
        cycle_count    = 0;
        test_name      = "reset";
        for (int i = 0; i < `RS_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            tag_busy[t]  = 1'b0;
            tag_value[t] = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        check_registers("reset"); // all zero and idle, stray results fail in the monitor
        run_test("independent", MODE_INDEP, 40);
        run_test("chain", MODE_CHAIN, 30);
        stall_count = 0;
        run_test("mul_heavy", MODE_MUL, 30);
        if (stall_count == 0) begin
            abort_run("mul_heavy: the station never filled, in_ready did not drop");
        end
        run_test("random_mix", MODE_MIX, 300);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
hdl/rs_pkg.sv
hdl/dispatch_stage.sv
hdl/reservation_station.sv
hdl/alu_stage.sv
hdl/ooo_core_top.sv
verification/tb_clock_gen.sv
verification/ooo_core_props.sv
verification/ooo_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the out-of-order core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module ooo_core_tb -o ooo_core_sim

status=0
out=$(./obj_dir/ooo_core_sim) || status=$?
printf '%s\n' "$out"
echo "simulator exit status $status"

# the verdict comes from the printed pass line only
printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"
